// ==== mem_unit.f ====
+incdir+common
common/mem_bus_pkg.sv
common/mem_perf_pkg.sv
cache/l1_cache.sv
verilog/mem_arb.sv
verilog/mem_perf_counters.sv
verilog/mem_unit.sv
verification/mem_model.sv
verification/mem_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mem_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_bus_pkg.sv
      - common/mem_perf_pkg.sv
      - cache/l1_cache.sv
      - verilog/mem_arb.sv
      - verilog/mem_perf_counters.sv
      - verilog/mem_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/mem_model.sv
      - verification/mem_unit_tb.sv

// ==== verification/mem_unit_tb.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module mem_unit_tb
    import mem_bus_pkg::*;
    import mem_perf_pkg::*;
;
    localparam int MAX_LINES = (`ICACHE_LINES > `DCACHE_LINES) ? `ICACHE_LINES : `DCACHE_LINES;

    logic      clk;
    logic      reset;
    logic      icache_req_valid;
    core_req_t icache_req;
    logic      icache_req_ready;
    logic      icache_rsp_valid;
    core_rsp_t icache_rsp;
    logic      icache_rsp_ready;
    logic      dcache_req_valid;
    core_req_t dcache_req;
    logic      dcache_req_ready;
    logic      dcache_rsp_valid;
    core_rsp_t dcache_rsp;
    logic      dcache_rsp_ready;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_ready;
    mem_perf_t perf;

    int errors;
    int checks;
    int issued;
    int cycles;
    int exp_reads;
    int exp_writes;
    int seen_stalls;

    // Reference memory words and the lines each cache should hold
    logic [31:0]                shadow [logic [31:0]];
    logic                       present [2][MAX_LINES];
    logic [`LINE_ADDR_BITS-1:0] held_line [2][MAX_LINES];

    mem_unit uut (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req       (icache_req),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp       (icache_rsp),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req       (dcache_req),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp       (dcache_rsp),
        .dcache_rsp_ready (dcache_rsp_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .mem_rsp_ready    (mem_rsp_ready),
        .perf             (perf)
    );

    mem_model mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory port stalls as seen from outside
    always @(negedge clk) begin
        if (!reset && mem_req_valid && !mem_req_ready) begin
            seen_stalls++;
        end
    end

    // Budget grows with every issued request
    initial begin
        cycles = 0;
        while (cycles <= 40 * issued + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout, run stopped after %0d cycles with %0d requests", cycles, issued);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_core_rsp(input string name, input core_rsp_t exp, input core_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected data %h tag %h, actual data %h tag %h",
                     name, exp.data, exp.tag, act.data, act.tag);
        end
    endtask

    task automatic check_perf(input string name, input mem_perf_t exp, input mem_perf_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected reads %0d writes %0d stalls %0d, actual %0d %0d %0d",
                     name, exp.mem_reads, exp.mem_writes, exp.mem_stalls,
                     act.mem_reads, act.mem_writes, act.mem_stalls);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:2], 2'b00};
        return shadow.exists(waddr) ? shadow[waddr] : (waddr ^ 32'h5a5a0000);
    endfunction

    function automatic int line_index(input int port, input logic [31:0] addr);
        int num_lines;
        num_lines = (port == 0) ? `ICACHE_LINES : `DCACHE_LINES;
        return addr[31:4] % num_lines;
    endfunction

    function automatic logic predict_hit(input int port, input logic [31:0] addr);
        int idx;
        idx = line_index(port, addr);
        return present[port][idx] && (held_line[port][idx] == addr[31:4]);
    endfunction

    function automatic logic req_ready_of(input int port);
        return (port == 0) ? icache_req_ready : dcache_req_ready;
    endfunction

    function automatic logic rsp_valid_of(input int port);
        return (port == 0) ? icache_rsp_valid : dcache_rsp_valid;
    endfunction

    function automatic core_rsp_t rsp_of(input int port);
        return (port == 0) ? icache_rsp : dcache_rsp;
    endfunction

    task automatic drive_req(input int port, input logic valid, input core_req_t req);
        if (port == 0) begin
            icache_req_valid = valid;
            icache_req       = req;
        end else begin
            dcache_req_valid = valid;
            dcache_req       = req;
        end
    endtask

    task automatic set_rsp_ready(input int port, input logic ready);
        if (port == 0) begin
            icache_rsp_ready = ready;
        end else begin
            dcache_rsp_ready = ready;
        end
    endtask

    task automatic send_req(input int port, input core_req_t req);
        @(posedge clk);
        #2;
        drive_req(port, 1'b1, req);
        issued++;
        do begin
            @(negedge clk);
        end while (!req_ready_of(port));
        @(posedge clk);
        #2;
        drive_req(port, 1'b0, '0);
    endtask

    task automatic wait_rsp(input int port, output core_rsp_t rsp, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rsp_valid_of(port));
        rsp = rsp_of(port);
    endtask

    // Hold > 0 keeps rsp_ready low for that many cycles of valid response
    task automatic read_word(input int port, input logic [31:0] addr, input int hold,
                             input string name);
        core_req_t req;
        core_rsp_t exp;
        core_rsp_t got;
        logic      hit;
        int        waited;
        hit        = predict_hit(port, addr);
        req        = '0;
        req.op     = MEM_READ;
        req.addr   = addr;
        req.byteen = '1;
        req.tag    = `CORE_TAG_BITS'($urandom);
        exp.data   = expected_word(addr);
        exp.tag    = req.tag;
        if (hold > 0) begin
            @(posedge clk);
            #2;
            set_rsp_ready(port, 1'b0);
        end
        send_req(port, req);
        wait_rsp(port, got, waited);
        check_core_rsp(name, exp, got);
        if (hit && waited != 1) begin
            errors++;
            $display("ERROR: %s hit answered %0d cycles after acceptance", name, waited);
        end
        for (int i = 1; i < hold; i++) begin
            @(negedge clk);
            if (!rsp_valid_of(port) || req_ready_of(port)) begin
                errors++;
                $display("ERROR: %s response dropped or request ready raised while held", name);
            end
            check_core_rsp({name, "_held"}, exp, rsp_of(port));
        end
        if (hold > 0) begin
            @(posedge clk);
            #2;
            set_rsp_ready(port, 1'b1);
        end
        if (!hit) begin
            present[port][line_index(port, addr)]   = 1'b1;
            held_line[port][line_index(port, addr)] = addr[31:4];
            exp_reads++;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] byteen);
        core_req_t   req;
        logic [31:0] new_word;
        req        = '0;
        req.op     = MEM_WRITE;
        req.addr   = addr;
        req.byteen = byteen;
        req.data   = $urandom;
        req.tag    = `CORE_TAG_BITS'($urandom);
        send_req(1, req);
        new_word = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (byteen[b]) begin
                new_word[b * 8 +: 8] = req.data[b * 8 +: 8];
            end
        end
        shadow[{addr[31:2], 2'b00}] = new_word;
        exp_writes++;
    endtask

    task automatic cold_and_hit_reads();
        read_word(0, 32'h0000_1040, 0, "icache_cold");
        read_word(0, 32'h0000_1040, 0, "icache_hit");
        read_word(0, 32'h0000_2040, 0, "icache_conflict");
        read_word(0, 32'h0000_1040, 0, "icache_refill");
    endtask

    task automatic write_through_reads();
        read_word(1, 32'h0000_3100, 0, "dcache_fill");
        write_word(32'h0000_3100, 4'b0110);
        read_word(1, 32'h0000_3100, 0, "dcache_merged_hit");
        write_word(32'h0000_3208, 4'b1111);
        read_word(1, 32'h0000_3208, 0, "dcache_write_miss");
        read_word(0, 32'h0000_3100, 0, "icache_after_write");
    endtask

    task automatic dual_port_misses();
        fork
            read_word(0, 32'h0000_4080, 0, "dual_icache");
            read_word(1, 32'h0000_50c0, 0, "dual_dcache");
        join
    endtask

    task automatic held_response();
        read_word(0, 32'h0000_1044, 10, "icache_rsp_hold");
    endtask

    task automatic counter_totals();
        mem_perf_t exp;
        repeat (5) @(posedge clk);
        @(negedge clk);
        exp.mem_reads  = exp_reads;
        exp.mem_writes = exp_writes;
        exp.mem_stalls = seen_stalls;
        check_perf("perf_counters", exp, perf);
    endtask

    initial begin
        void'($urandom(32'hb319a8f1));
        errors           = 0;
        checks           = 0;
        issued           = 0;
        exp_reads        = 0;
        exp_writes       = 0;
        seen_stalls      = 0;
        present          = '{default: 1'b0};
        reset            = 1'b1;
        icache_req_valid = 1'b0;
        icache_req       = '0;
        icache_rsp_ready = 1'b1;
        dcache_req_valid = 1'b0;
        dcache_req       = '0;
        dcache_rsp_ready = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        cold_and_hit_reads();
        write_through_reads();
        dual_port_misses();
        held_response();
        counter_totals();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module mem_model
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_req_ready,

    output logic     mem_rsp_valid,
    output mem_rsp_t mem_rsp,
    input  logic     mem_rsp_ready
);
    localparam int OFS_BITS = `ADDR_BITS - `LINE_ADDR_BITS;

    logic [`LINE_BITS-1:0]    lines [logic [`LINE_ADDR_BITS-1:0]];
    logic [`LINE_BITS-1:0]    rsp_data_q [$];
    logic [`MEM_TAG_BITS-1:0] rsp_tag_q [$];
    int unsigned              rsp_due_q [$];
    int unsigned              cyc;
    logic [`LINE_BITS-1:0]    wr_line;

    // Lines never written hold their own word addresses, scrambled
    function automatic logic [`LINE_BITS-1:0] read_line(
        input logic [`LINE_ADDR_BITS-1:0] line_addr
    );
        logic [`ADDR_BITS-1:0] base;
        logic [`LINE_BITS-1:0] data;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        base = {line_addr, {OFS_BITS{1'b0}}};
        for (int w = 0; w < `LINE_WORDS; w++) begin
            data[w * `WORD_BITS +: `WORD_BITS] = (base + w * 4) ^ 32'h5a5a0000;
        end
        return data;
    endfunction

    // Every fourth cycle the port is busy
    assign mem_req_ready = !reset && (cyc % 4 != 3);

    always @(posedge clk) begin
        if (reset) begin
            cyc           <= 0;
            mem_rsp_valid <= 1'b0;
            mem_rsp       <= '0;
            rsp_data_q.delete();
            rsp_tag_q.delete();
            rsp_due_q.delete();
        end else begin
            cyc <= cyc + 1;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_data_q.pop_front());
                void'(rsp_tag_q.pop_front());
                void'(rsp_due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.op == MEM_WRITE) begin
                    wr_line = read_line(mem_req.line_addr);
                    for (int b = 0; b < `LINE_BITS / 8; b++) begin
                        if (mem_req.byteen[b]) begin
                            wr_line[b * 8 +: 8] = mem_req.data[b * 8 +: 8];
                        end
                    end
                    lines[mem_req.line_addr] = wr_line;
                end else begin
                    rsp_data_q.push_back(read_line(mem_req.line_addr));
                    rsp_tag_q.push_back(mem_req.tag);
                    rsp_due_q.push_back(cyc + 3);
                end
            end
            // Head of the queue goes out once its latency has passed
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc + 1) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp.data  <= rsp_data_q[0];
                mem_rsp.tag   <= rsp_tag_q[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/mem_unit.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module mem_unit
    import mem_bus_pkg::*;
    import mem_perf_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      icache_req_valid,
    input  core_req_t icache_req,
    output logic      icache_req_ready,
    output logic      icache_rsp_valid,
    output core_rsp_t icache_rsp,
    input  logic      icache_rsp_ready,

    input  logic      dcache_req_valid,
    input  core_req_t dcache_req,
    output logic      dcache_req_ready,
    output logic      dcache_rsp_valid,
    output core_rsp_t dcache_rsp,
    input  logic      dcache_rsp_ready,

    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  mem_rsp_t  mem_rsp,
    output logic      mem_rsp_ready,

    output mem_perf_t perf
);
    // Index 0 is the icache, 1 the dcache
    logic     [1:0] cache_req_valid;
    mem_req_t [1:0] cache_req;
    logic     [1:0] cache_req_ready;
    logic     [1:0] cache_rsp_valid;
    mem_rsp_t [1:0] cache_rsp;
    logic     [1:0] cache_rsp_ready;

    l1_cache #(
        .NUM_LINES    (`ICACHE_LINES),
        .WRITE_ENABLE (1'b0)
    ) icache (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (icache_req_valid),
        .core_req       (icache_req),
        .core_req_ready (icache_req_ready),
        .core_rsp_valid (icache_rsp_valid),
        .core_rsp       (icache_rsp),
        .core_rsp_ready (icache_rsp_ready),
        .mem_req_valid  (cache_req_valid[0]),
        .mem_req        (cache_req[0]),
        .mem_req_ready  (cache_req_ready[0]),
        .mem_rsp_valid  (cache_rsp_valid[0]),
        .mem_rsp        (cache_rsp[0]),
        .mem_rsp_ready  (cache_rsp_ready[0])
    );

    l1_cache #(
        .NUM_LINES    (`DCACHE_LINES),
        .WRITE_ENABLE (1'b1)
    ) dcache (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (dcache_req_valid),
        .core_req       (dcache_req),
        .core_req_ready (dcache_req_ready),
        .core_rsp_valid (dcache_rsp_valid),
        .core_rsp       (dcache_rsp),
        .core_rsp_ready (dcache_rsp_ready),
        .mem_req_valid  (cache_req_valid[1]),
        .mem_req        (cache_req[1]),
        .mem_req_ready  (cache_req_ready[1]),
        .mem_rsp_valid  (cache_rsp_valid[1]),
        .mem_rsp        (cache_rsp[1]),
        .mem_rsp_ready  (cache_rsp_ready[1])
    );

    mem_arb arb (
        .clk           (clk),
        .reset         (reset),
        .src_req_valid (cache_req_valid),
        .src_req       (cache_req),
        .src_req_ready (cache_req_ready),
        .src_rsp_valid (cache_rsp_valid),
        .src_rsp       (cache_rsp),
        .src_rsp_ready (cache_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    mem_perf_counters perf_ctr (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_op    (mem_req.op),
        .mem_req_ready (mem_req_ready),
        .perf          (perf)
    );

endmodule

// ==== verilog/mem_perf_counters.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module mem_perf_counters
    import mem_bus_pkg::*;
    import mem_perf_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      mem_req_valid,
    input  mem_op_e   mem_req_op,
    input  logic      mem_req_ready,

    output mem_perf_t perf
);
    logic req_fire;

    assign req_fire = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            if (req_fire && mem_req_op == MEM_READ) begin
                perf.mem_reads <= perf.mem_reads + `PERF_CTR_BITS'(1);
            end
            if (req_fire && mem_req_op == MEM_WRITE) begin
                perf.mem_writes <= perf.mem_writes + `PERF_CTR_BITS'(1);
            end
            // Request waiting on the memory
            if (mem_req_valid && !mem_req_ready) begin
                perf.mem_stalls <= perf.mem_stalls + `PERF_CTR_BITS'(1);
            end
        end
    end

endmodule

// ==== verilog/mem_arb.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module mem_arb
    import mem_bus_pkg::*;
(
    input  logic           clk,
    input  logic           reset,

    input  logic     [1:0] src_req_valid,
    input  mem_req_t [1:0] src_req,
    output logic     [1:0] src_req_ready,

    output logic     [1:0] src_rsp_valid,
    output mem_rsp_t [1:0] src_rsp,
    input  logic     [1:0] src_rsp_ready,

    output logic           mem_req_valid,
    output mem_req_t       mem_req,
    input  logic           mem_req_ready,

    input  logic           mem_rsp_valid,
    input  mem_rsp_t       mem_rsp,
    output logic           mem_rsp_ready
);
    logic       prio;
    logic       hold_q;
    logic [1:0] grant_q;
    logic [1:0] grant;
    logic       sel;
    logic       rsp_sel;

    always_comb begin
        if (hold_q) begin
            // Keep a stalled request on the port until it is taken
            grant = grant_q;
        end else if (&src_req_valid) begin
            grant = prio ? 2'b10 : 2'b01;
        end else begin
            grant = src_req_valid;
        end
    end

    assign sel           = grant[1];
    assign mem_req_valid = |grant;
    assign src_req_ready = grant & {2{mem_req_ready}};

    always_comb begin
        mem_req     = src_req[sel];
        mem_req.tag = `MEM_TAG_BITS'(sel);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio    <= 1'b0;
            hold_q  <= 1'b0;
            grant_q <= '0;
        end else begin
            hold_q  <= mem_req_valid && !mem_req_ready;
            grant_q <= grant;
            if (mem_req_valid && mem_req_ready) begin
                prio <= ~sel;
            end
        end
    end

    // Steer responses back by the source id in the tag
    assign rsp_sel = mem_rsp.tag[0];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_rsp_valid[i] = mem_rsp_valid && (rsp_sel == 1'(i));
            src_rsp[i]       = mem_rsp;
        end
    end

    assign mem_rsp_ready = src_rsp_ready[rsp_sel];

endmodule

// ==== cache/l1_cache.sv ====
`timescale 1ns/100ps
`include "mem_unit_config.svh"

module l1_cache
    import mem_bus_pkg::*;
#(
    parameter int NUM_LINES    = 16,
    parameter bit WRITE_ENABLE = 1'b0
) (
    input  logic      clk,
    input  logic      reset,

    input  logic      core_req_valid,
    input  core_req_t core_req,
    output logic      core_req_ready,

    output logic      core_rsp_valid,
    output core_rsp_t core_rsp,
    input  logic      core_rsp_ready,

    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,

    input  logic      mem_rsp_valid,
    input  mem_rsp_t  mem_rsp,
    output logic      mem_rsp_ready
);
    localparam int IDX_SHIFT  = $clog2(NUM_LINES);
    localparam int IDX_BITS   = (IDX_SHIFT > 0) ? IDX_SHIFT : 1;
    localparam int TAG_BITS   = `LINE_ADDR_BITS - IDX_SHIFT;
    localparam int WORD_BYTES = `WORD_BITS / 8;
    localparam int OFS_LSB    = $clog2(WORD_BYTES);
    localparam int WOFS_BITS  = $clog2(`LINE_WORDS);
    localparam int LINE_LSB   = `ADDR_BITS - `LINE_ADDR_BITS;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MISS_REQ,
        ST_MISS_WAIT,
        ST_WRITE,
        ST_RSP
    } cache_state_e;

    cache_state_e state;

    logic [NUM_LINES-1:0]  valid_bits;
    logic [TAG_BITS-1:0]   tag_mem [NUM_LINES];
    logic [`LINE_BITS-1:0] data_mem [NUM_LINES];

    core_req_t             req_q;
    logic [`WORD_BITS-1:0] rsp_data_q;

    logic [`LINE_ADDR_BITS-1:0] in_line;
    logic [IDX_BITS-1:0]        in_idx;
    logic [WOFS_BITS-1:0]       in_wofs;
    logic [`LINE_ADDR_BITS-1:0] q_line;
    logic [IDX_BITS-1:0]        q_idx;
    logic [WOFS_BITS-1:0]       q_wofs;
    logic                       in_hit;
    logic                       in_write;
    logic                       req_fire;
    logic                       fill;
    logic [`LINE_BITS-1:0]      merged_line;

    // Lookup on the incoming request, so a hit answers next cycle
    assign in_line  = core_req.addr[`ADDR_BITS-1:LINE_LSB];
    assign in_idx   = IDX_BITS'(in_line & (NUM_LINES - 1));
    assign in_wofs  = core_req.addr[OFS_LSB +: WOFS_BITS];
    assign in_hit   = valid_bits[in_idx]
                   && (tag_mem[in_idx] == in_line[`LINE_ADDR_BITS-1:IDX_SHIFT]);
    assign in_write = WRITE_ENABLE && (core_req.op == MEM_WRITE);

    assign q_line = req_q.addr[`ADDR_BITS-1:LINE_LSB];
    assign q_idx  = IDX_BITS'(q_line & (NUM_LINES - 1));
    assign q_wofs = req_q.addr[OFS_LSB +: WOFS_BITS];

    assign core_req_ready = (state == ST_IDLE);
    assign req_fire       = core_req_valid && core_req_ready;
    assign fill           = (state == ST_MISS_WAIT) && mem_rsp_valid;

    always_comb begin
        merged_line = data_mem[in_idx];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (core_req.byteen[b]) begin
                merged_line[in_wofs * `WORD_BITS + b * 8 +: 8] = core_req.data[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            valid_bits <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_fire) begin
                        if (in_write) begin
                            state <= ST_WRITE;
                        end else if (in_hit) begin
                            state <= ST_RSP;
                        end else begin
                            state <= ST_MISS_REQ;
                        end
                    end
                end
                ST_MISS_REQ: begin
                    if (mem_req_ready) begin
                        state <= ST_MISS_WAIT;
                    end
                end
                ST_MISS_WAIT: begin
                    if (mem_rsp_valid) begin
                        state             <= ST_RSP;
                        valid_bits[q_idx] <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    // Write-through done, no core response
                    if (mem_req_ready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RSP: begin
                    if (core_rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q      <= core_req;
            rsp_data_q <= data_mem[in_idx][in_wofs * `WORD_BITS +: `WORD_BITS];
            if (in_write && in_hit) begin
                data_mem[in_idx] <= merged_line;
            end
        end
        if (fill) begin
            data_mem[q_idx] <= mem_rsp.data;
            tag_mem[q_idx]  <= q_line[`LINE_ADDR_BITS-1:IDX_SHIFT];
            rsp_data_q      <= mem_rsp.data[q_wofs * `WORD_BITS +: `WORD_BITS];
        end
    end

    assign core_rsp_valid = (state == ST_RSP);
    assign core_rsp.data  = rsp_data_q;
    assign core_rsp.tag   = req_q.tag;

    assign mem_req_valid = (state == ST_MISS_REQ) || (state == ST_WRITE);
    assign mem_rsp_ready = (state == ST_MISS_WAIT);

    always_comb begin
        mem_req.op        = (state == ST_WRITE) ? MEM_WRITE : MEM_READ;
        mem_req.line_addr = q_line;
        mem_req.data      = {`LINE_WORDS{req_q.data}};
        mem_req.tag       = '0;
        if (state == ST_WRITE) begin
            mem_req.byteen = '0;
            mem_req.byteen[q_wofs * WORD_BYTES +: WORD_BYTES] = req_q.byteen;
        end else begin
            mem_req.byteen = '1;
        end
    end

endmodule

// ==== common/mem_perf_pkg.sv ====
`include "mem_unit_config.svh"

package mem_perf_pkg;

    // Memory port activity
    typedef struct packed {
        logic [`PERF_CTR_BITS-1:0] mem_reads;
        logic [`PERF_CTR_BITS-1:0] mem_writes;
        logic [`PERF_CTR_BITS-1:0] mem_stalls;
    } mem_perf_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
`include "mem_unit_config.svh"

package mem_bus_pkg;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Core side, one word per request
    typedef struct packed {
        mem_op_e                    op;
        logic [`ADDR_BITS-1:0]      addr;
        logic [`WORD_BITS/8-1:0]    byteen;
        logic [`WORD_BITS-1:0]      data;
        logic [`CORE_TAG_BITS-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [`WORD_BITS-1:0]      data;
        logic [`CORE_TAG_BITS-1:0]  tag;
    } core_rsp_t;

    // Memory side, one full line per request
    typedef struct packed {
        mem_op_e                    op;
        logic [`LINE_ADDR_BITS-1:0] line_addr;
        logic [`LINE_BITS/8-1:0]    byteen;
        logic [`LINE_BITS-1:0]      data;
        logic [`MEM_TAG_BITS-1:0]   tag;
    } mem_req_t;

    typedef struct packed {
        logic [`LINE_BITS-1:0]      data;
        logic [`MEM_TAG_BITS-1:0]   tag;
    } mem_rsp_t;

endpackage

// ==== common/mem_unit_config.svh ====
`ifndef MEM_UNIT_CONFIG_SVH
`define MEM_UNIT_CONFIG_SVH

// Core word and cache line geometry
`define WORD_BITS       32
`define LINE_WORDS      4
`define LINE_BITS       128

// Byte address, and line address without the line offset
`define ADDR_BITS       32
`define LINE_ADDR_BITS  28

// Tags
`define CORE_TAG_BITS   4
`define MEM_TAG_BITS    1

// Cache sizes in lines
`define ICACHE_LINES    16
`define DCACHE_LINES    16

`define PERF_CTR_BITS   32

`endif
